// ==== hw/mem_sys_pkg.sv ====
//////////////////////////////////////////////////
// address map, word typedefs and data-port structs
// shared by the memory system RTL
//////////////////////////////////////////////////
`default_nettype none

package mem_sys_pkg;

  // basic vector types
  typedef logic [31:0] byte_addr_t;
  typedef logic [29:0] word_addr_t;
  typedef logic [31:0] half_t;
  typedef logic [64:0] cap_word_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [63:0] fetch_word_t;

  //////////////////////////////////////////////////
  // address map, in word-address bits
  //////////////////////////////////////////////////

  // data RAM at 0x8000_0000
  localparam int DRAM_BASE_BIT = 29;
  // tag-status RAM at 0x8300_0000, compared with bits 29..22
  localparam logic [7:0] TSRAM_TAG = 8'h83;
  // control registers at 0x8380_0000, compared with bits 29..8
  localparam logic [21:0] MMREG_TAG = {8'h83, 1'b1, 13'h0};

  // control register word offsets
  localparam logic [7:0] REG_SCRATCH0 = 8'h00;
  localparam logic [7:0] REG_SCRATCH1 = 8'h01;
  localparam logic [7:0] REG_ERR_EN   = 8'h40;
  localparam logic [7:0] REG_INTR_ACK = 8'h41;
  localparam logic [7:0] REG_DEBUG    = 8'h50;

  localparam half_t REG_DEFAULT = 32'hdead_beef;

  //////////////////////////////////////////////////
  // data port
  //////////////////////////////////////////////////

  typedef struct packed {
    logic       valid;
    logic       we;
    byte_en_t   be;
    logic       is_cap;
    logic       lr;
    logic       sc;
    word_addr_t addr;
    cap_word_t  wdata;
  } data_req_t;

  typedef struct packed {
    logic      rvalid;
    cap_word_t rdata;
    logic      err;
    logic      sc_fail;
  } data_rsp_t;

  // byte-enabled update of one 32-bit half
  function automatic half_t be_merge(half_t old_val, half_t new_val, byte_en_t be);
    half_t merged;
    merged = old_val;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

// ==== hw/data_port_router.sv ====
//////////////////////////////////////////////////
// data port address decode and response mux
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module data_port_router import mem_sys_pkg::*; #(
  parameter int dram_aw  = 8,
  parameter int tsram_aw = 6
) (
  input  logic      clk,
  input  logic      rst_n,
  input  data_req_t req,
  input  cap_word_t dram_rdata,
  input  logic      dram_sc_fail,
  input  half_t     tsram_rdata,
  input  half_t     reg_rdata,
  output logic      dram_sel,
  output logic      tsram_sel,
  output logic      reg_sel,
  output data_rsp_t rsp
);

  logic dram_hit;
  logic tsram_hit;
  logic reg_hit;
  logic unmapped;

  logic rvalid_q;
  logic err_q;
  logic dram_q;
  logic tsram_q;
  logic reg_q;

  // region match, nothing above each array range may be set
  assign dram_hit  = req.addr[DRAM_BASE_BIT] &&
                     (req.addr[DRAM_BASE_BIT-1:dram_aw+1] == '0);
  assign tsram_hit = (req.addr[29:22] == TSRAM_TAG) && !req.addr[21] &&
                     (req.addr[20:tsram_aw] == '0);
  assign reg_hit   = (req.addr[29:8] == MMREG_TAG);

  assign dram_sel  = req.valid && dram_hit;
  assign tsram_sel = req.valid && tsram_hit;
  assign reg_sel   = req.valid && reg_hit;
  assign unmapped  = req.valid && !(dram_hit || tsram_hit || reg_hit);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      dram_q   <= 1'b0;
      tsram_q  <= 1'b0;
      reg_q    <= 1'b0;
    end else begin
      rvalid_q <= req.valid;
      err_q    <= unmapped;
      dram_q   <= dram_sel;
      tsram_q  <= tsram_sel;
      reg_q    <= reg_sel;
    end
  end

  // no target selected on error, so rdata falls to zero
  always_comb begin
    rsp.rvalid  = rvalid_q;
    rsp.err     = err_q;
    rsp.sc_fail = dram_q && dram_sc_fail;
    rsp.rdata   = '0;
    if (dram_q) begin
      rsp.rdata = dram_rdata;
    end else if (tsram_q) begin
      rsp.rdata = {33'h0, tsram_rdata};
    end else if (reg_q) begin
      rsp.rdata = {33'h0, reg_rdata};
    end
  end

endmodule

`default_nettype wire

// ==== hw/cap_data_ram.sv ====
//////////////////////////////////////////////////
// 65-bit tagged data RAM
// data port with LR/SC reservation, instruction fetch port
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cap_data_ram import mem_sys_pkg::*; #(
  parameter int dram_aw         = 8,
  parameter bit unaligned_fetch = 1'b1
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        sel,
  input  data_req_t   req,
  input  logic        instr_req,
  input  byte_addr_t  instr_addr,
  output cap_word_t   rdata,
  output logic        sc_fail,
  output logic        instr_rvalid,
  output fetch_word_t instr_rdata
);

  localparam int DEPTH = 2**dram_aw;

  cap_word_t mem [DEPTH];

  logic [dram_aw-1:0] idx;
  logic               half_sel;
  logic               wr_en;
  logic               resv_q;
  cap_word_t          wr_word;

  word_addr_t         fetch_wa;
  logic [dram_aw-1:0] fetch_idx;
  logic               fetch_hit;
  fetch_word_t        fetch_data;

  // two 32-bit words per RAM entry
  assign idx      = req.addr[dram_aw:1];
  assign half_sel = req.addr[0];

  // a store-conditional only lands while the reservation holds
  assign wr_en = sel && req.we && (!req.sc || resv_q);

  //////////////////////////////////////////////////
  // data port
  //////////////////////////////////////////////////
  always_comb begin
    wr_word = mem[idx];
    if (req.is_cap) begin
      wr_word = req.wdata;
    end else if (half_sel) begin
      wr_word[63:32] = be_merge(mem[idx][63:32], req.wdata[31:0], req.be);
    end else begin
      wr_word[31:0] = be_merge(mem[idx][31:0], req.wdata[31:0], req.be);
    end
    // tag always follows the write data
    wr_word[64] = req.wdata[64];
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[idx] <= wr_word;
    end
    if (sel) begin
      if (req.we) begin
        rdata <= '0;
      end else if (req.is_cap) begin
        rdata <= mem[idx];
      end else if (half_sel) begin
        rdata <= {33'h0, mem[idx][63:32]};
      end else begin
        rdata <= {33'h0, mem[idx][31:0]};
      end
    end
  end

  // reservation set by a load-reserved and dropped by any write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resv_q  <= 1'b0;
      sc_fail <= 1'b0;
    end else begin
      sc_fail <= sel && req.we && req.sc && !resv_q;
      if (sel && !req.we && req.lr) begin
        resv_q <= 1'b1;
      end else if (sel && req.we) begin
        resv_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // instruction fetch
  //////////////////////////////////////////////////
  assign fetch_wa  = instr_addr[31:2];
  assign fetch_idx = fetch_wa[dram_aw:1];
  assign fetch_hit = fetch_wa[DRAM_BASE_BIT] &&
                     (fetch_wa[DRAM_BASE_BIT-1:dram_aw+1] == '0);

  always_comb begin
    fetch_data = '0;
    if (fetch_hit) begin
      if (unaligned_fetch && fetch_wa[0]) begin
        // straddles into the next entry
        fetch_data = {mem[fetch_idx + dram_aw'(1)][31:0], mem[fetch_idx][63:32]};
      end else begin
        fetch_data = mem[fetch_idx][63:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_rvalid <= 1'b0;
    end else begin
      instr_rvalid <= instr_req;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_req) begin
      instr_rdata <= fetch_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/tag_status_ram.sv ====
//////////////////////////////////////////////////
// 32-bit tag-status RAM
// byte-enabled data port plus read-only lookup port
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tag_status_ram import mem_sys_pkg::*; #(
  parameter int tsram_aw = 6
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        sel,
  input  data_req_t   req,
  input  logic        tsmap_cs,
  input  logic [15:0] tsmap_addr,
  output half_t       rdata,
  output half_t       tsmap_rdata
);

  localparam int DEPTH = 2**tsram_aw;

  half_t mem [DEPTH];

  logic [tsram_aw-1:0] p0_idx;
  logic [tsram_aw-1:0] p1_idx;

  assign p0_idx = req.addr[tsram_aw-1:0];
  assign p1_idx = tsmap_addr[tsram_aw-1:0];

  // array starts out all zero after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      rdata       <= '0;
      tsmap_rdata <= '0;
    end else begin
      // port 0
      if (sel) begin
        if (req.we) begin
          mem[p0_idx] <= be_merge(mem[p0_idx], req.wdata[31:0], req.be);
          rdata       <= '0;
        end else begin
          rdata <= mem[p0_idx];
        end
      end

      // port 1, lookup only
      if (tsmap_cs) begin
        tsmap_rdata <= mem[p1_idx];
      end else begin
        tsmap_rdata <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/ctrl_regs.sv ====
//////////////////////////////////////////////////
// memory-mapped control registers
// scratch, error enable, interrupt ack, debug request
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs import mem_sys_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sel,
  input  data_req_t  req,
  output half_t      rdata,
  output logic [3:0] err_enable_vec,
  output logic [2:0] intr_ack,
  output logic       debug_req
);

  logic [7:0] offset;
  logic       wr;

  half_t      scratch0;
  half_t      scratch1;
  logic [7:0] dbg_req_cnt;
  logic [7:0] dbg_ack_cnt;
  half_t      rd_val;

  assign offset = req.addr[7:0];
  assign wr     = sel && req.we;

  //////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scratch0       <= '0;
      scratch1       <= '0;
      err_enable_vec <= '0;
      intr_ack       <= '0;
      debug_req      <= 1'b0;
      dbg_req_cnt    <= '0;
      dbg_ack_cnt    <= '0;
    end else begin
      if (wr && offset == REG_SCRATCH0) begin
        scratch0 <= req.wdata[31:0];
      end
      if (wr && offset == REG_SCRATCH1) begin
        scratch1 <= req.wdata[31:0];
      end
      if (wr && offset == REG_ERR_EN) begin
        err_enable_vec <= req.wdata[3:0];
      end

      // single-cycle pulse
      if (wr && offset == REG_INTR_ACK) begin
        intr_ack <= req.wdata[2:0];
      end else begin
        intr_ack <= '0;
      end

      // debug request level, plus request/ack counts
      if (wr && offset == REG_DEBUG) begin
        debug_req <= req.wdata[0];
        if (req.wdata[0]) begin
          dbg_req_cnt <= dbg_req_cnt + 8'd1;
        end else begin
          dbg_ack_cnt <= dbg_ack_cnt + 8'd1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // register reads
  //////////////////////////////////////////////////
  always_comb begin
    case (offset)
      REG_SCRATCH0: rd_val = scratch0;
      REG_SCRATCH1: rd_val = scratch1;
      REG_DEBUG:    rd_val = {dbg_req_cnt, dbg_ack_cnt, 16'h0};
      default:      rd_val = REG_DEFAULT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sel) begin
      rdata <= req.we ? '0 : rd_val;
    end
  end

endmodule

`default_nettype wire

// ==== hw/mem_sys_top.sv ====
//////////////////////////////////////////////////
// memory system top level
// data port router, data RAM, tag-status RAM, registers
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_sys_top import mem_sys_pkg::*; #(
  parameter int dram_aw         = 8,
  parameter int tsram_aw        = 6,
  parameter bit unaligned_fetch = 1'b1
) (
  input  logic        clk,
  input  logic        rst_n,

  // data port
  input  data_req_t   data_req,
  output data_rsp_t   data_rsp,

  // instruction fetch port
  input  logic        instr_req,
  input  byte_addr_t  instr_addr,
  output logic        instr_rvalid,
  output fetch_word_t instr_rdata,

  // tag-status lookup port
  input  logic        tsmap_cs,
  input  logic [15:0] tsmap_addr,
  output half_t       tsmap_rdata,

  // control outputs
  output logic [3:0]  err_enable_vec,
  output logic [2:0]  intr_ack,
  output logic        debug_req
);

  logic      dram_sel;
  logic      tsram_sel;
  logic      reg_sel;
  cap_word_t dram_rdata;
  logic      dram_sc_fail;
  half_t     tsram_rdata;
  half_t     reg_rdata;

  //////////////////////////////////////////////////
  // data port decode and response
  //////////////////////////////////////////////////
  data_port_router #(
    .dram_aw  (dram_aw),
    .tsram_aw (tsram_aw)
  ) router_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (data_req),
    .dram_rdata   (dram_rdata),
    .dram_sc_fail (dram_sc_fail),
    .tsram_rdata  (tsram_rdata),
    .reg_rdata    (reg_rdata),
    .dram_sel     (dram_sel),
    .tsram_sel    (tsram_sel),
    .reg_sel      (reg_sel),
    .rsp          (data_rsp)
  );

  //////////////////////////////////////////////////
  // targets
  //////////////////////////////////////////////////
  cap_data_ram #(
    .dram_aw         (dram_aw),
    .unaligned_fetch (unaligned_fetch)
  ) dram_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .sel          (dram_sel),
    .req          (data_req),
    .instr_req    (instr_req),
    .instr_addr   (instr_addr),
    .rdata        (dram_rdata),
    .sc_fail      (dram_sc_fail),
    .instr_rvalid (instr_rvalid),
    .instr_rdata  (instr_rdata)
  );

  tag_status_ram #(
    .tsram_aw (tsram_aw)
  ) tsram_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .sel         (tsram_sel),
    .req         (data_req),
    .tsmap_cs    (tsmap_cs),
    .tsmap_addr  (tsmap_addr),
    .rdata       (tsram_rdata),
    .tsmap_rdata (tsmap_rdata)
  );

  ctrl_regs regs_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .sel            (reg_sel),
    .req            (data_req),
    .rdata          (reg_rdata),
    .err_enable_vec (err_enable_vec),
    .intr_ack       (intr_ack),
    .debug_req      (debug_req)
  );

endmodule

`default_nettype wire

// ==== test/mem_sys_chk.sv ====
//////////////////////////////////////////////////
// concurrent assertions on the top-level ports
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_sys_chk import mem_sys_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input data_req_t  data_req,
  input data_rsp_t  data_rsp,
  input logic [2:0] intr_ack
);

  // response exactly one cycle after each request
  a_rvalid_follows: assert property (@(posedge clk) disable iff (!rst_n)
    data_req.valid |=> data_rsp.rvalid)
    else $error("rvalid missing one cycle after a request");

  a_no_spurious_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    !data_req.valid |=> !data_rsp.rvalid)
    else $error("rvalid without a request one cycle before");

  // single-cycle pulse
  a_intr_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    (intr_ack != 3'b0) |=> (intr_ack == 3'b0))
    else $error("intr_ack high two cycles running");

  a_err_rdata_zero: assert property (@(posedge clk) disable iff (!rst_n)
    data_rsp.err |-> (data_rsp.rdata == '0))
    else $error("error response with nonzero rdata");

endmodule

bind mem_sys_top mem_sys_chk chk_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .data_req (data_req),
  .data_rsp (data_rsp),
  .intr_ack (intr_ack)
);

`default_nettype wire

// ==== test/mem_sys_tb.sv ====
//////////////////////////////////////////////////
// memory system testbench
// xorshift random stimulus, reference model, checks
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_sys_tb import mem_sys_pkg::*; ();

  localparam int N_RAND = 600;
  // random ops plus an upper bound on the directed ones
  localparam int N_OPS  = N_RAND + 200;

  logic        clk;
  logic        rst_n;
  data_req_t   data_req;
  data_rsp_t   data_rsp;
  logic        instr_req;
  byte_addr_t  instr_addr;
  logic        instr_rvalid;
  fetch_word_t instr_rdata;
  logic        tsmap_cs;
  logic [15:0] tsmap_addr;
  half_t       tsmap_rdata;
  logic [3:0]  err_enable_vec;
  logic [2:0]  intr_ack;
  logic        debug_req;

  // reference model state
  cap_word_t   dram_m [256];
  half_t       ts_m [64];
  half_t       scratch0_m;
  half_t       scratch1_m;
  logic [3:0]  err_en_m;
  logic        debug_m;
  logic [7:0]  req_cnt_m;
  logic [7:0]  ack_cnt_m;
  logic        resv_m;

  // what the DUT should show after the next edge
  data_rsp_t   exp_rsp;
  logic        exp_irv;
  fetch_word_t exp_idata;
  half_t       exp_ts;
  logic [2:0]  exp_intr;

  logic [31:0] seed;

  mem_sys_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req       (data_req),
    .data_rsp       (data_rsp),
    .instr_req      (instr_req),
    .instr_addr     (instr_addr),
    .instr_rvalid   (instr_rvalid),
    .instr_rdata    (instr_rdata),
    .tsmap_cs       (tsmap_cs),
    .tsmap_addr     (tsmap_addr),
    .tsmap_rdata    (tsmap_rdata),
    .err_enable_vec (err_enable_vec),
    .intr_ack       (intr_ack),
    .debug_req      (debug_req)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(20 * N_OPS + 500);
    $display("Watchdog: run did not finish within %0d ns", 20 * N_OPS + 500);
    $display("Test failed");
    $fatal(1, "watchdog timeout");
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rnd();
    seed = xorshift(seed);
    return seed;
  endfunction

  function automatic cap_word_t rand_cap();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = rnd();
    b = rnd();
    c = rnd();
    return {c[0], a, b};
  endfunction

  // word addresses of the three regions
  function automatic word_addr_t dram_wa(input logic [7:0] idx, input logic half);
    return {1'b1, 20'h0, idx, half};
  endfunction

  function automatic word_addr_t ts_wa(input logic [5:0] idx);
    return {8'h83, 16'h0, idx};
  endfunction

  function automatic word_addr_t reg_wa(input logic [7:0] off);
    return {8'h83, 1'b1, 13'h0, off};
  endfunction

  function automatic data_req_t make_req(input logic we, input logic cap, input byte_en_t be,
                                         input logic lr, input logic sc, input word_addr_t a,
                                         input cap_word_t wd);
    data_req_t r;
    r.valid  = 1'b1;
    r.we     = we;
    r.be     = be;
    r.is_cap = cap;
    r.lr     = lr;
    r.sc     = sc;
    r.addr   = a;
    r.wdata  = wd;
    return r;
  endfunction

  function automatic half_t merge_bytes(input half_t old_v, input half_t new_v,
                                        input byte_en_t be);
    half_t m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = be[b] ? new_v[8*b +: 8] : old_v[8*b +: 8];
    end
    return m;
  endfunction

  task automatic check_eq(input string what, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  //////////////////////////////////////////////////
  // reference model of the data port
  //////////////////////////////////////////////////
  task automatic model_data(input data_req_t r);
    data_rsp_t  e;
    cap_word_t  w;
    logic [7:0] idx;
    logic [5:0] tidx;
    logic [7:0] off;
    e        = '0;
    idx      = r.addr[8:1];
    tidx     = r.addr[5:0];
    off      = r.addr[7:0];
    exp_intr = 3'b0;
    if (r.valid) begin
      e.rvalid = 1'b1;
      if (r.addr[29] && r.addr[28:9] == 20'h0) begin
        w = dram_m[idx];
        if (r.we) begin
          e.sc_fail = r.sc && !resv_m;
          if (!r.sc || resv_m) begin
            if (r.is_cap) begin
              w = r.wdata;
            end else if (r.addr[0]) begin
              w[63:32] = merge_bytes(w[63:32], r.wdata[31:0], r.be);
            end else begin
              w[31:0] = merge_bytes(w[31:0], r.wdata[31:0], r.be);
            end
            w[64] = r.wdata[64];
            dram_m[idx] = w;
          end
          resv_m = 1'b0;
        end else begin
          if (r.is_cap) begin
            e.rdata = w;
          end else if (r.addr[0]) begin
            e.rdata = {33'h0, w[63:32]};
          end else begin
            e.rdata = {33'h0, w[31:0]};
          end
          if (r.lr) begin
            resv_m = 1'b1;
          end
        end
      end else if (r.addr[29:21] == {8'h83, 1'b0} && r.addr[20:6] == 15'h0) begin
        if (r.we) begin
          ts_m[tidx] = merge_bytes(ts_m[tidx], r.wdata[31:0], r.be);
        end else begin
          e.rdata = {33'h0, ts_m[tidx]};
        end
      end else if (r.addr[29:8] == {8'h83, 1'b1, 13'h0}) begin
        if (r.we) begin
          case (off)
            8'h00: scratch0_m = r.wdata[31:0];
            8'h01: scratch1_m = r.wdata[31:0];
            8'h40: err_en_m = r.wdata[3:0];
            8'h41: exp_intr = r.wdata[2:0];
            8'h50: begin
              debug_m = r.wdata[0];
              if (r.wdata[0]) begin
                req_cnt_m = req_cnt_m + 8'd1;
              end else begin
                ack_cnt_m = ack_cnt_m + 8'd1;
              end
            end
            default: ;
          endcase
        end else begin
          case (off)
            8'h00:   e.rdata = {33'h0, scratch0_m};
            8'h01:   e.rdata = {33'h0, scratch1_m};
            8'h50:   e.rdata = {33'h0, req_cnt_m, ack_cnt_m, 16'h0};
            default: e.rdata = {33'h0, 32'hdead_beef};
          endcase
        end
      end else begin
        e.err = 1'b1;
      end
    end
    exp_rsp = e;
  endtask

  // one clock: check last cycle's prediction, then drive the next inputs
  task automatic run_cycle(input data_req_t r, input logic ireq, input byte_addr_t iaddr,
                           input logic tcs, input logic [15:0] taddr);
    word_addr_t  fwa;
    logic [7:0]  fidx;
    fetch_word_t fw;
    @(posedge clk);
    #1;
    check_eq("data_rsp", 128'(data_rsp), 128'(exp_rsp));
    check_eq("instr_rvalid", 128'(instr_rvalid), 128'(exp_irv));
    if (exp_irv) begin
      check_eq("instr_rdata", 128'(instr_rdata), 128'(exp_idata));
    end
    check_eq("tsmap_rdata", 128'(tsmap_rdata), 128'(exp_ts));
    check_eq("err_enable_vec", 128'(err_enable_vec), 128'(err_en_m));
    check_eq("intr_ack", 128'(intr_ack), 128'(exp_intr));
    check_eq("debug_req", 128'(debug_req), 128'(debug_m));

    // read ports see the memory before this cycle's write
    fwa  = iaddr[31:2];
    fidx = fwa[8:1];
    fw   = '0;
    if (fwa[29] && fwa[28:9] == 20'h0) begin
      if (fwa[0]) begin
        fw = {dram_m[fidx + 8'd1][31:0], dram_m[fidx][63:32]};
      end else begin
        fw = dram_m[fidx][63:0];
      end
    end
    exp_irv   = ireq;
    exp_idata = fw;
    exp_ts    = tcs ? ts_m[taddr[5:0]] : '0;
    model_data(r);

    data_req   = r;
    instr_req  = ireq;
    instr_addr = iaddr;
    tsmap_cs   = tcs;
    tsmap_addr = taddr;
  endtask

  task automatic data_op(input data_req_t r);
    run_cycle(r, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic idle_cycle();
    run_cycle('0, 1'b0, '0, 1'b0, '0);
  endtask

  //////////////////////////////////////////////////
  // test phases
  //////////////////////////////////////////////////
  task automatic test_reset_state();
    for (int i = 0; i < 4; i++) begin
      run_cycle(make_req(1'b0, 1'b0, '0, 1'b0, 1'b0, ts_wa(6'(i)), '0),
                1'b0, '0, 1'b1, 16'(i));
    end
    data_op(make_req(1'b0, 1'b0, '0, 1'b0, 1'b0, reg_wa(8'h00), '0));
    data_op(make_req(1'b0, 1'b0, '0, 1'b0, 1'b0, reg_wa(8'h50), '0));
  endtask

  // data RAM has no reset, fill the test window first
  task automatic preload_dram();
    for (int i = 0; i < 16; i++) begin
      data_op(make_req(1'b1, 1'b1, 4'hf, 1'b0, 1'b0, dram_wa(8'(i), 1'b0), rand_cap()));
    end
  endtask

  task automatic test_lr_sc();
    data_op(make_req(1'b0, 1'b1, '0, 1'b1, 1'b0, dram_wa(8'd3, 1'b0), '0));
    data_op(make_req(1'b1, 1'b1, 4'hf, 1'b0, 1'b1, dram_wa(8'd3, 1'b0), rand_cap()));
    data_op(make_req(1'b0, 1'b1, '0, 1'b0, 1'b0, dram_wa(8'd3, 1'b0), '0));
    data_op(make_req(1'b0, 1'b1, '0, 1'b1, 1'b0, dram_wa(8'd3, 1'b0), '0));
    data_op(make_req(1'b1, 1'b0, 4'h3, 1'b0, 1'b0, dram_wa(8'd5, 1'b1), rand_cap()));
    data_op(make_req(1'b1, 1'b1, 4'hf, 1'b0, 1'b1, dram_wa(8'd3, 1'b0), rand_cap()));
    data_op(make_req(1'b0, 1'b1, '0, 1'b0, 1'b0, dram_wa(8'd3, 1'b0), '0));
    // no reservation at all
    data_op(make_req(1'b1, 1'b0, 4'hf, 1'b0, 1'b1, dram_wa(8'd4, 1'b1), rand_cap()));
  endtask

  task automatic test_tsram();
    logic [31:0] r;
    for (int i = 0; i < 8; i++) begin
      r = rnd();
      data_op(make_req(1'b1, 1'b0, r[3:0], 1'b0, 1'b0, ts_wa(6'(i)), {33'h0, rnd()}));
    end
    for (int i = 0; i < 8; i++) begin
      run_cycle(make_req(1'b0, 1'b0, '0, 1'b0, 1'b0, ts_wa(6'(i)), '0),
                1'b0, '0, 1'b1, 16'(7 - i));
    end
    run_cycle('0, 1'b0, '0, 1'b0, 16'd2);
  endtask

  task automatic test_regs();
    data_op(make_req(1'b1, 1'b0, 4'hf, 1'b0, 1'b0, reg_wa(8'h00), {33'h0, rnd()}));
    data_op(make_req(1'b1, 1'b0, 4'hf, 1'b0, 1'b0, reg_wa(8'h01), {33'h0, rnd()}));
    data_op(make_req(1'b0, 1'b0, '0, 1'b0, 1'b0, reg_wa(8'h00), '0));
    data_op(make_req(1'b0, 1'b0, '0, 1'b0, 1'b0, reg_wa(8'h01), '0));
    data_op(make_req(1'b1, 1'b0, 4'hf, 1'b0, 1'b0, reg_wa(8'h40), {33'h0, 32'h0000_000a}));
    data_op(make_req(1'b0, 1'b0, '0, 1'b0, 1'b0, reg_wa(8'h40), '0));
    data_op(make_req(1'b1, 1'b0, 4'hf, 1'b0, 1'b0, reg_wa(8'h41), {33'h0, 32'h0000_0005}));
    idle_cycle();
    idle_cycle();
    data_op(make_req(1'b1, 1'b0, 4'hf, 1'b0, 1'b0, reg_wa(8'h50), {33'h0, 32'h1}));
    data_op(make_req(1'b1, 1'b0, 4'hf, 1'b0, 1'b0, reg_wa(8'h50), {33'h0, 32'h1}));
    data_op(make_req(1'b1, 1'b0, 4'hf, 1'b0, 1'b0, reg_wa(8'h50), {33'h0, 32'h0}));
    data_op(make_req(1'b0, 1'b0, '0, 1'b0, 1'b0, reg_wa(8'h50), '0));
    data_op(make_req(1'b0, 1'b0, '0, 1'b0, 1'b0, reg_wa(8'h23), '0));
    // unmapped: low space, above the data RAM, above the tag-status RAM
    data_op(make_req(1'b1, 1'b0, 4'hf, 1'b0, 1'b0, 30'h0000_1234, rand_cap()));
    data_op(make_req(1'b0, 1'b0, '0, 1'b0, 1'b0, {1'b1, 20'h00100, 8'h00, 1'b0}, '0));
    data_op(make_req(1'b0, 1'b0, '0, 1'b0, 1'b0, {8'h83, 16'h0001, 6'h0}, '0));
  endtask

  task automatic test_fetch();
    for (int i = 0; i < 30; i++) begin
      run_cycle('0, 1'b1, {1'b1, 24'h0, 5'(i), 2'b00}, 1'b0, '0);
    end
    run_cycle('0, 1'b1, 32'h0000_1000, 1'b0, '0);
    run_cycle('0, 1'b1, 32'h9000_0000, 1'b0, '0);
    idle_cycle();
  endtask

  task automatic test_random();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    data_req_t   req;
    logic [7:0]  off;
    logic        we;
    logic        prev_intr;
    logic [4:0]  fwa;
    prev_intr = 1'b0;
    for (int n = 0; n < N_RAND; n++) begin
      r0  = rnd();
      r1  = rnd();
      r2  = rnd();
      we  = r0[3];
      req = '0;
      case (r0[2:0])
        3'd0, 3'd1, 3'd2, 3'd3:
          req = make_req(we, r0[4], r0[8:5], !we && r0[9], we && r0[9],
                         dram_wa({4'h0, r0[13:10]}, r0[14]), {r0[15], r1, r2});
        3'd4, 3'd5:
          req = make_req(we, 1'b0, r0[8:5], 1'b0, 1'b0, ts_wa({2'b00, r0[13:10]}),
                         {33'h0, r1});
        3'd6: begin
          case (r0[12:10])
            3'd0:    off = 8'h00;
            3'd1:    off = 8'h01;
            3'd2:    off = 8'h40;
            3'd3:    off = 8'h41;
            3'd4:    off = 8'h50;
            default: off = r2[7:0];
          endcase
          // interrupt ack pulses never run back to back
          if (off == 8'h41 && prev_intr) begin
            we = 1'b0;
          end
          req = make_req(we, 1'b0, 4'hf, 1'b0, 1'b0, reg_wa(off), {33'h0, r1});
        end
        default:
          req = make_req(we, 1'b0, r0[8:5], 1'b0, 1'b0,
                         {r0[4], r0[4], r1[27:0]}, {r0[15], r1, r2});
      endcase
      prev_intr = (r0[2:0] == 3'd6) && we && (off == 8'h41);
      fwa = r0[21:17];
      if (fwa > 5'd29) begin
        fwa = fwa - 5'd8;
      end
      run_cycle(req, r0[16], {1'b1, 24'h0, fwa, 2'b00}, r0[22], {12'h0, r0[26:23]});
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    seed       = 32'hf692;
    rst_n      = 1'b0;
    data_req   = '0;
    instr_req  = 1'b0;
    instr_addr = '0;
    tsmap_cs   = 1'b0;
    tsmap_addr = '0;
    exp_rsp    = '0;
    exp_irv    = 1'b0;
    exp_idata  = '0;
    exp_ts     = '0;
    exp_intr   = '0;
    for (int i = 0; i < 256; i++) begin
      dram_m[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      ts_m[i] = '0;
    end
    scratch0_m = '0;
    scratch1_m = '0;
    err_en_m   = '0;
    debug_m    = 1'b0;
    req_cnt_m  = '0;
    ack_cnt_m  = '0;
    resv_m     = 1'b0;

    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset_state();
    preload_dram();
    test_lr_sc();
    test_tsram();
    test_regs();
    test_fetch();
    test_random();
    idle_cycle();

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mem_sys_top.f ====
hw/mem_sys_pkg.sv
hw/data_port_router.sv
hw/cap_data_ram.sv
hw/tag_status_ram.sv
hw/ctrl_regs.sv
hw/mem_sys_top.sv
test/mem_sys_chk.sv
test/mem_sys_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory system testbench

VERILATOR ?= verilator
TOP       ?= mem_sys_tb
FILELIST  ?= mem_sys_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
	  echo "simulation FAILED, see $(LOG)"; exit 1; \
	else \
	  echo "simulation ok"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
